//--- logic/interconnect_pkg.sv
package interconnect_pkg;

    // Bus geometry
    localparam int WB_ADDR_W   = 24;
    localparam int WB_DATA_W   = 16;
    localparam int WB_SEL_BITS = 2;

    // RAM windows
    localparam logic [WB_ADDR_W-1:0] NE_INTMEM_BEGIN = 24'h7ffe00;
    localparam logic [WB_ADDR_W-1:0] E_PROG_START    = 24'h800000;
    localparam logic [WB_ADDR_W-1:0] E_MEM_START     = 24'h100000;
    localparam logic [WB_ADDR_W-1:0] INTMEM_SIZE     = 24'h100;

    // Word index width inside one RAM window
    localparam int IRAM_AW = $clog2(INTMEM_SIZE);

    // Register addresses
    localparam logic [WB_ADDR_W-1:0] CLK_DIV_ADDR  = 24'h001001;
    localparam logic [WB_ADDR_W-1:0] GPIO_OUT_ADDR = 24'h001010;
    localparam logic [WB_ADDR_W-1:0] GPIO_DIR_ADDR = 24'h001011;
    localparam logic [WB_ADDR_W-1:0] GPIO_IN_ADDR  = 24'h001012;

    localparam int GPIO_N    = 8;
    localparam int CLK_DIV_W = 4;

    typedef enum logic [1:0] {
        TGT_IRAM,
        TGT_GPIO,
        TGT_CLKDIV,
        TGT_NONE
    } wb_target_e;

endpackage

//--- logic/wb_bus_if.sv
interface wb_bus_if;
    import interconnect_pkg::*;

    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [WB_ADDR_W-1:0]   adr;
    logic [WB_SEL_BITS-1:0] sel;
    logic [WB_DATA_W-1:0]   dat_w;
    logic [WB_DATA_W-1:0]   dat_r;
    logic                   ack;
    logic                   err;

    modport master (
        output cyc, stb, we, adr, sel, dat_w,
        input  dat_r, ack, err
    );

    modport slave (
        input  cyc, stb, we, adr, sel, dat_w,
        output dat_r, ack, err
    );

endinterface

//--- logic/wb_arbiter.sv
module wb_arbiter (
    input  logic     i_core_clock,
    input  logic     i_core_reset,
    wb_bus_if.slave  i_m0,
    wb_bus_if.slave  i_m1,
    wb_bus_if.master o_bus
);
    import interconnect_pkg::*;

    logic gnt_valid;
    logic gnt_sel;
    logic req_cyc;

    // cyc of whichever master holds the grant
    assign req_cyc = gnt_sel ? i_m1.cyc : i_m0.cyc;

    always_ff @(posedge i_core_clock) begin
        if (i_core_reset) begin
            gnt_valid <= 1'b0;
            gnt_sel   <= 1'b0;
        end else if (!gnt_valid) begin
            // Master 0 wins a tie
            if (i_m0.cyc) begin
                gnt_valid <= 1'b1;
                gnt_sel   <= 1'b0;
            end else if (i_m1.cyc) begin
                gnt_valid <= 1'b1;
                gnt_sel   <= 1'b1;
            end
        end else if (!req_cyc) begin
            gnt_valid <= 1'b0;
        end
    end

    // Request path
    assign o_bus.cyc   = gnt_valid & req_cyc;
    assign o_bus.stb   = gnt_valid & (gnt_sel ? i_m1.stb : i_m0.stb);
    assign o_bus.we    = gnt_sel ? i_m1.we : i_m0.we;
    assign o_bus.adr   = gnt_sel ? i_m1.adr : i_m0.adr;
    assign o_bus.sel   = gnt_sel ? i_m1.sel : i_m0.sel;
    assign o_bus.dat_w = gnt_sel ? i_m1.dat_w : i_m0.dat_w;

    // Response goes to the granted master only
    assign i_m0.ack   = gnt_valid & ~gnt_sel & o_bus.ack;
    assign i_m0.err   = gnt_valid & ~gnt_sel & o_bus.err;
    assign i_m0.dat_r = (gnt_valid & ~gnt_sel) ? o_bus.dat_r : '0;

    assign i_m1.ack   = gnt_valid & gnt_sel & o_bus.ack;
    assign i_m1.err   = gnt_valid & gnt_sel & o_bus.err;
    assign i_m1.dat_r = (gnt_valid & gnt_sel) ? o_bus.dat_r : '0;

endmodule

//--- logic/wb_target_select.sv
module wb_target_select (
    input  logic     i_core_clock,
    input  logic     i_core_reset,
    input  logic     i_embed_mode,
    wb_bus_if.slave  i_bus,
    wb_bus_if.master o_iram,
    wb_bus_if.master o_gpio,
    output logic     o_clkdiv_we,
    output logic [interconnect_pkg::CLK_DIV_W-1:0] o_clkdiv_data
);
    import interconnect_pkg::*;

    logic [1:0] embed_ff;
    logic       embed_mode;
    logic       req;
    wb_target_e tgt;

    function automatic logic in_window(input logic [WB_ADDR_W-1:0] adr,
                                       input logic [WB_ADDR_W-1:0] base);
        in_window = (adr >= base) && (adr < base + INTMEM_SIZE);
    endfunction

    // Two-flop synchronizer for the embed pin
    always_ff @(posedge i_core_clock) begin
        if (i_core_reset) begin
            embed_ff <= 2'b00;
        end else begin
            embed_ff <= {embed_ff[0], i_embed_mode};
        end
    end

    assign embed_mode = embed_ff[1];
    assign req        = i_bus.cyc & i_bus.stb;

    always_comb begin
        if (embed_mode && (in_window(i_bus.adr, E_PROG_START) ||
                           in_window(i_bus.adr, E_MEM_START))) begin
            tgt = TGT_IRAM;
        end else if (!embed_mode && in_window(i_bus.adr, NE_INTMEM_BEGIN)) begin
            tgt = TGT_IRAM;
        end else if (i_bus.adr == CLK_DIV_ADDR) begin
            tgt = TGT_CLKDIV;
        end else if (i_bus.adr >= GPIO_OUT_ADDR && i_bus.adr <= GPIO_IN_ADDR) begin
            tgt = TGT_GPIO;
        end else begin
            // Old off-chip bridge space lands here too
            tgt = TGT_NONE;
        end
    end

    // Request fan-out with stb only toward the selected target
    assign o_iram.cyc   = i_bus.cyc;
    assign o_iram.stb   = i_bus.stb & (tgt == TGT_IRAM);
    assign o_iram.we    = i_bus.we;
    assign o_iram.adr   = i_bus.adr;
    assign o_iram.sel   = i_bus.sel;
    assign o_iram.dat_w = i_bus.dat_w;

    assign o_gpio.cyc   = i_bus.cyc;
    assign o_gpio.stb   = i_bus.stb & (tgt == TGT_GPIO);
    assign o_gpio.we    = i_bus.we;
    assign o_gpio.adr   = i_bus.adr;
    assign o_gpio.sel   = i_bus.sel;
    assign o_gpio.dat_w = i_bus.dat_w;

    assign o_clkdiv_we   = req & i_bus.we & (tgt == TGT_CLKDIV);
    assign o_clkdiv_data = i_bus.dat_w[CLK_DIV_W-1:0];

    always_comb begin
        case (tgt)
            TGT_IRAM: begin
                i_bus.ack   = o_iram.ack;
                i_bus.err   = o_iram.err;
                i_bus.dat_r = o_iram.dat_r;
            end
            TGT_GPIO: begin
                i_bus.ack   = o_gpio.ack;
                i_bus.err   = o_gpio.err;
                i_bus.dat_r = o_gpio.dat_r;
            end
            TGT_CLKDIV: begin
                // Same-cycle ack with a zero readback
                i_bus.ack   = req;
                i_bus.err   = 1'b0;
                i_bus.dat_r = '0;
            end
            default: begin
                i_bus.ack   = 1'b0;
                i_bus.err   = req;
                i_bus.dat_r = '0;
            end
        endcase
    end

endmodule

//--- logic/wb_iram.sv
module wb_iram (
    input  logic    i_core_clock,
    input  logic    i_core_reset,
    wb_bus_if.slave i_bus
);
    import interconnect_pkg::*;

    logic [WB_DATA_W-1:0] mem [0:(1 << IRAM_AW)-1];
    logic [IRAM_AW-1:0]   idx;
    logic                 access;
    logic                 ack_q;
    logic [WB_DATA_W-1:0] rd_q;

    assign idx    = i_bus.adr[IRAM_AW-1:0];
    // No new access in the ack cycle
    assign access = i_bus.cyc & i_bus.stb & ~ack_q;

    always_ff @(posedge i_core_clock) begin
        if (access && i_bus.we) begin
            for (int b = 0; b < WB_SEL_BITS; b++) begin
                if (i_bus.sel[b]) begin
                    mem[idx][b*8 +: 8] <= i_bus.dat_w[b*8 +: 8];
                end
            end
        end
        rd_q <= mem[idx];
    end

    always_ff @(posedge i_core_clock) begin
        if (i_core_reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign i_bus.ack   = ack_q;
    assign i_bus.err   = 1'b0;
    assign i_bus.dat_r = rd_q;

endmodule

//--- logic/wb_gpio.sv
module wb_gpio (
    input  logic    i_core_clock,
    input  logic    i_core_reset,
    wb_bus_if.slave i_bus,
    input  logic [interconnect_pkg::GPIO_N-1:0] i_gpio_in,
    output logic [interconnect_pkg::GPIO_N-1:0] o_gpio_out,
    output logic [interconnect_pkg::GPIO_N-1:0] o_gpio_dir
);
    import interconnect_pkg::*;

    logic [GPIO_N-1:0]    in_s1;
    logic [GPIO_N-1:0]    in_s2;
    logic                 access;
    logic                 ack_q;
    logic [WB_DATA_W-1:0] rd_q;

    assign access = i_bus.cyc & i_bus.stb & ~ack_q;

    // Pin synchronizer
    always_ff @(posedge i_core_clock) begin
        in_s1 <= i_gpio_in;
        in_s2 <= in_s1;
    end

    always_ff @(posedge i_core_clock) begin
        if (i_core_reset) begin
            o_gpio_out <= '0;
            o_gpio_dir <= '0;
            ack_q      <= 1'b0;
        end else begin
            ack_q <= access;
            if (access && i_bus.we && i_bus.sel[0]) begin
                if (i_bus.adr == GPIO_OUT_ADDR) begin
                    o_gpio_out <= i_bus.dat_w[GPIO_N-1:0];
                end else if (i_bus.adr == GPIO_DIR_ADDR) begin
                    o_gpio_dir <= i_bus.dat_w[GPIO_N-1:0];
                end
            end
        end
    end

    always_ff @(posedge i_core_clock) begin
        if (access) begin
            case (i_bus.adr)
                GPIO_OUT_ADDR: rd_q <= {{(WB_DATA_W-GPIO_N){1'b0}}, o_gpio_out};
                GPIO_DIR_ADDR: rd_q <= {{(WB_DATA_W-GPIO_N){1'b0}}, o_gpio_dir};
                default:       rd_q <= {{(WB_DATA_W-GPIO_N){1'b0}}, in_s2};
            endcase
        end
    end

    assign i_bus.ack   = ack_q;
    assign i_bus.err   = 1'b0;
    assign i_bus.dat_r = rd_q;

endmodule

//--- logic/clk_div.sv
module clk_div (
    input  logic i_core_clock,
    input  logic i_core_reset,
    input  logic i_div_we,
    input  logic [interconnect_pkg::CLK_DIV_W-1:0] i_div,
    output logic o_clk
);
    import interconnect_pkg::*;

    logic [CLK_DIV_W-1:0] div_q;
    logic [CLK_DIV_W-1:0] count;

    // o_clk flips every div_q+1 cycles
    always_ff @(posedge i_core_clock) begin
        if (i_core_reset) begin
            div_q <= '0;
            count <= '0;
            o_clk <= 1'b0;
        end else if (i_div_we) begin
            div_q <= i_div;
            count <= '0;
        end else if (count == div_q) begin
            count <= '0;
            o_clk <= ~o_clk;
        end else begin
            count <= count + CLK_DIV_W'(1);
        end
    end

endmodule

//--- logic/interconnect_outer.sv
module interconnect_outer (
    input  logic                                    i_core_clock,
    input  logic                                    i_core_reset,

    input  logic                                    i_m0_cyc,
    input  logic                                    i_m0_stb,
    input  logic                                    i_m0_we,
    input  logic [interconnect_pkg::WB_ADDR_W-1:0]   i_m0_adr,
    input  logic [interconnect_pkg::WB_SEL_BITS-1:0] i_m0_sel,
    input  logic [interconnect_pkg::WB_DATA_W-1:0]   i_m0_dat,
    output logic [interconnect_pkg::WB_DATA_W-1:0]   o_m0_dat,
    output logic                                    o_m0_ack,
    output logic                                    o_m0_err,

    input  logic                                    i_m1_cyc,
    input  logic                                    i_m1_stb,
    input  logic                                    i_m1_we,
    input  logic [interconnect_pkg::WB_ADDR_W-1:0]   i_m1_adr,
    input  logic [interconnect_pkg::WB_SEL_BITS-1:0] i_m1_sel,
    input  logic [interconnect_pkg::WB_DATA_W-1:0]   i_m1_dat,
    output logic [interconnect_pkg::WB_DATA_W-1:0]   o_m1_dat,
    output logic                                    o_m1_ack,
    output logic                                    o_m1_err,

    input  logic                                    i_embed_mode,
    input  logic [interconnect_pkg::GPIO_N-1:0]      i_gpio_in,
    output logic [interconnect_pkg::GPIO_N-1:0]      o_gpio_out,
    output logic [interconnect_pkg::GPIO_N-1:0]      o_gpio_dir,
    output logic                                    o_div_clk
);

    wb_bus_if m0_bus ();
    wb_bus_if m1_bus ();
    wb_bus_if m_bus ();
    wb_bus_if iram_bus ();
    wb_bus_if gpio_bus ();

    logic                                 clkdiv_we;
    logic [interconnect_pkg::CLK_DIV_W-1:0] clkdiv_data;

    // External port master
    assign m0_bus.cyc   = i_m0_cyc;
    assign m0_bus.stb   = i_m0_stb;
    assign m0_bus.we    = i_m0_we;
    assign m0_bus.adr   = i_m0_adr;
    assign m0_bus.sel   = i_m0_sel;
    assign m0_bus.dat_w = i_m0_dat;
    assign o_m0_dat     = m0_bus.dat_r;
    assign o_m0_ack     = m0_bus.ack;
    assign o_m0_err     = m0_bus.err;

    // Inner core master
    assign m1_bus.cyc   = i_m1_cyc;
    assign m1_bus.stb   = i_m1_stb;
    assign m1_bus.we    = i_m1_we;
    assign m1_bus.adr   = i_m1_adr;
    assign m1_bus.sel   = i_m1_sel;
    assign m1_bus.dat_w = i_m1_dat;
    assign o_m1_dat     = m1_bus.dat_r;
    assign o_m1_ack     = m1_bus.ack;
    assign o_m1_err     = m1_bus.err;

    wb_arbiter wb_arbiter_inst (
        .i_core_clock (i_core_clock),
        .i_core_reset (i_core_reset),
        .i_m0         (m0_bus),
        .i_m1         (m1_bus),
        .o_bus        (m_bus)
    );

    wb_target_select wb_target_select_inst (
        .i_core_clock  (i_core_clock),
        .i_core_reset  (i_core_reset),
        .i_embed_mode  (i_embed_mode),
        .i_bus         (m_bus),
        .o_iram        (iram_bus),
        .o_gpio        (gpio_bus),
        .o_clkdiv_we   (clkdiv_we),
        .o_clkdiv_data (clkdiv_data)
    );

    wb_iram wb_iram_inst (
        .i_core_clock (i_core_clock),
        .i_core_reset (i_core_reset),
        .i_bus        (iram_bus)
    );

    wb_gpio wb_gpio_inst (
        .i_core_clock (i_core_clock),
        .i_core_reset (i_core_reset),
        .i_bus        (gpio_bus),
        .i_gpio_in    (i_gpio_in),
        .o_gpio_out   (o_gpio_out),
        .o_gpio_dir   (o_gpio_dir)
    );

    clk_div clk_div_inst (
        .i_core_clock (i_core_clock),
        .i_core_reset (i_core_reset),
        .i_div_we     (clkdiv_we),
        .i_div        (clkdiv_data),
        .o_clk        (o_div_clk)
    );

endmodule

//--- sim/tb_interconnect_outer.sv
module tb_interconnect_outer;
    timeunit 1ns;
    timeprecision 1ps;
    import interconnect_pkg::*;

    localparam int BUS_TIMEOUT = 50;

    logic                          core_clock = 1'b0;
    logic                          core_reset;
    logic [1:0]                    m_cyc;
    logic [1:0]                    m_stb;
    logic [1:0]                    m_we;
    logic [1:0][WB_ADDR_W-1:0]     m_adr;
    logic [1:0][WB_SEL_BITS-1:0]   m_sel;
    logic [1:0][WB_DATA_W-1:0]     m_dat;
    wire  [1:0][WB_DATA_W-1:0]     m_rdat;
    wire  [1:0]                    m_ack;
    wire  [1:0]                    m_err;
    logic                          embed_mode;
    logic [GPIO_N-1:0]             gpio_in;
    wire  [GPIO_N-1:0]             gpio_out;
    wire  [GPIO_N-1:0]             gpio_dir;
    wire                           div_clk;

    integer               seed = 32'hcd96;
    int                   cycle_cnt = 0;
    int                   errors;
    int                   tests;
    int                   ack_cyc [2];
    int                   drop_cyc [2];
    logic [WB_DATA_W-1:0] mem_model [0:(1 << IRAM_AW)-1];
    logic [GPIO_N-1:0]    gpio_out_model;
    logic [GPIO_N-1:0]    gpio_dir_model;
    logic                 embed_model;

    always #50 core_clock = ~core_clock;

    always @(posedge core_clock) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    interconnect_outer interconnect_outer_inst (
        .i_core_clock (core_clock),
        .i_core_reset (core_reset),
        .i_m0_cyc     (m_cyc[0]),
        .i_m0_stb     (m_stb[0]),
        .i_m0_we      (m_we[0]),
        .i_m0_adr     (m_adr[0]),
        .i_m0_sel     (m_sel[0]),
        .i_m0_dat     (m_dat[0]),
        .o_m0_dat     (m_rdat[0]),
        .o_m0_ack     (m_ack[0]),
        .o_m0_err     (m_err[0]),
        .i_m1_cyc     (m_cyc[1]),
        .i_m1_stb     (m_stb[1]),
        .i_m1_we      (m_we[1]),
        .i_m1_adr     (m_adr[1]),
        .i_m1_sel     (m_sel[1]),
        .i_m1_dat     (m_dat[1]),
        .o_m1_dat     (m_rdat[1]),
        .o_m1_ack     (m_ack[1]),
        .o_m1_err     (m_err[1]),
        .i_embed_mode (embed_mode),
        .i_gpio_in    (gpio_in),
        .o_gpio_out   (gpio_out),
        .o_gpio_dir   (gpio_dir),
        .o_div_clk    (div_clk)
    );

    function automatic logic [WB_DATA_W-1:0] rand16();
        int r;
        r = $random(seed);
        return r[WB_DATA_W-1:0];
    endfunction

    function automatic logic [WB_DATA_W-1:0] pad_gpio(input logic [GPIO_N-1:0] v);
        return {{(WB_DATA_W-GPIO_N){1'b0}}, v};
    endfunction

    // Address map as seen from a master
    function automatic wb_target_e expect_target(input logic [WB_ADDR_W-1:0] adr,
                                                 input logic embed);
        if (embed && ((adr - E_PROG_START) < INTMEM_SIZE ||
                      (adr - E_MEM_START) < INTMEM_SIZE)) begin
            return TGT_IRAM;
        end
        if (!embed && (adr - NE_INTMEM_BEGIN) < INTMEM_SIZE) begin
            return TGT_IRAM;
        end
        if (adr == CLK_DIV_ADDR) begin
            return TGT_CLKDIV;
        end
        if (adr == GPIO_OUT_ADDR || adr == GPIO_DIR_ADDR || adr == GPIO_IN_ADDR) begin
            return TGT_GPIO;
        end
        return TGT_NONE;
    endfunction

    task automatic check_data(input string name, input logic [WB_DATA_W-1:0] got,
                              input logic [WB_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_gpio(input string name, input logic [GPIO_N-1:0] got,
                              input logic [GPIO_N-1:0] exp);
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input logic got_ack, input logic got_err,
                              input wb_target_e tgt);
        logic exp_ack;
        exp_ack = (tgt != TGT_NONE);
        if (got_ack !== exp_ack || got_err !== !exp_ack) begin
            $display("Error: %s = %h/%h, expected %h/%h",
                     name, got_ack, got_err, exp_ack, !exp_ack);
            errors++;
        end
    endtask

    // One classic cycle, held until ack or err
    task automatic bus_cycle(input int m, input logic we, input logic [WB_ADDR_W-1:0] adr,
                             input logic [WB_SEL_BITS-1:0] sel,
                             input logic [WB_DATA_W-1:0] wdat,
                             output logic [WB_DATA_W-1:0] rdat,
                             output logic got_ack, output logic got_err);
        int wait_cnt;
        @(posedge core_clock);
        #1;
        m_cyc[m] = 1'b1;
        m_stb[m] = 1'b1;
        m_we[m]  = we;
        m_adr[m] = adr;
        m_sel[m] = sel;
        m_dat[m] = wdat;
        got_ack  = 1'b0;
        got_err  = 1'b0;
        rdat     = '0;
        wait_cnt = 0;
        while (!got_ack && !got_err && wait_cnt < BUS_TIMEOUT) begin
            @(negedge core_clock);
            got_ack = m_ack[m];
            got_err = m_err[m];
            rdat    = m_rdat[m];
            wait_cnt++;
        end
        ack_cyc[m] = cycle_cnt;
        if (!got_ack && !got_err) begin
            $display("Master %0d got neither ack nor err within %0d cycles at address %h",
                     m, BUS_TIMEOUT, adr);
            errors++;
        end
        @(posedge core_clock);
        #1;
        m_cyc[m]    = 1'b0;
        m_stb[m]    = 1'b0;
        drop_cyc[m] = cycle_cnt;
    endtask

    task automatic bus_write(input int m, input logic [WB_ADDR_W-1:0] adr,
                             input logic [WB_SEL_BITS-1:0] sel,
                             input logic [WB_DATA_W-1:0] wdat,
                             output logic got_ack, output logic got_err);
        logic [WB_DATA_W-1:0] unused_rdat;
        bus_cycle(m, 1'b1, adr, sel, wdat, unused_rdat, got_ack, got_err);
    endtask

    task automatic bus_read(input int m, input logic [WB_ADDR_W-1:0] adr,
                            output logic [WB_DATA_W-1:0] rdat,
                            output logic got_ack, output logic got_err);
        bus_cycle(m, 1'b0, adr, '1, '0, rdat, got_ack, got_err);
    endtask

    task automatic write_expect(input int m, input logic [WB_ADDR_W-1:0] adr,
                                input logic [WB_SEL_BITS-1:0] sel,
                                input logic [WB_DATA_W-1:0] wdat);
        logic a;
        logic e;
        bus_write(m, adr, sel, wdat, a, e);
        check_resp($sformatf("o_m%0d_ack/o_m%0d_err write @%h", m, m, adr), a, e,
                   expect_target(adr, embed_model));
    endtask

    task automatic read_expect(input int m, input logic [WB_ADDR_W-1:0] adr,
                               input logic [WB_DATA_W-1:0] exp);
        logic [WB_DATA_W-1:0] rd;
        logic                 a;
        logic                 e;
        bus_read(m, adr, rd, a, e);
        check_resp($sformatf("o_m%0d_ack/o_m%0d_err read @%h", m, m, adr), a, e,
                   expect_target(adr, embed_model));
        check_data($sformatf("o_m%0d_dat @%h", m, adr), rd, exp);
    endtask

    task automatic finish_test(input string name, input int start_err);
        tests++;
        $display("%s: done, %0d errors", name, errors - start_err);
    endtask

    task automatic test_ram_normal();
        int                   start_err;
        logic [WB_DATA_W-1:0] d;
        start_err = errors;
        for (int k = 0; k < 16; k++) begin
            d = rand16();
            write_expect(0, NE_INTMEM_BEGIN + 24'(k), 2'b11, d);
            mem_model[k] = d;
        end
        for (int k = 0; k < 16; k++) begin
            read_expect(1, NE_INTMEM_BEGIN + 24'(k), mem_model[k]);
        end
        // Partial writes keep the other byte
        d = rand16();
        write_expect(0, NE_INTMEM_BEGIN + 24'd5, 2'b01, d);
        mem_model[5] = {mem_model[5][15:8], d[7:0]};
        read_expect(1, NE_INTMEM_BEGIN + 24'd5, mem_model[5]);
        d = rand16();
        write_expect(0, NE_INTMEM_BEGIN + 24'd6, 2'b10, d);
        mem_model[6] = {d[15:8], mem_model[6][7:0]};
        read_expect(1, NE_INTMEM_BEGIN + 24'd6, mem_model[6]);
        finish_test("ram normal mode", start_err);
    endtask

    // Poll a read at adr until it acks
    task automatic wait_for_window(input logic [WB_ADDR_W-1:0] adr);
        logic [WB_DATA_W-1:0] rd;
        logic                 a;
        logic                 e;
        int                   n;
        a = 1'b0;
        n = 0;
        while (!a && n < 10) begin
            bus_read(0, adr, rd, a, e);
            n++;
        end
        if (!a) begin
            $display("RAM window at %h never opened after the embed mode change", adr);
            errors++;
        end
    endtask

    task automatic test_embed();
        int                   start_err;
        logic [WB_DATA_W-1:0] d;
        start_err = errors;
        @(posedge core_clock);
        #1;
        embed_mode = 1'b1;
        wait_for_window(E_PROG_START);
        embed_model = 1'b1;
        for (int k = 0; k < 8; k++) begin
            d = rand16();
            write_expect(0, E_PROG_START + 24'(k), 2'b11, d);
            mem_model[k] = d;
        end
        for (int k = 0; k < 8; k++) begin
            read_expect(1, E_MEM_START + 24'(k), mem_model[k]);
        end
        d = rand16();
        write_expect(1, E_MEM_START + 24'd8, 2'b11, d);
        mem_model[8] = d;
        read_expect(0, E_PROG_START + 24'd8, mem_model[8]);
        // Normal window is closed now
        read_expect(0, NE_INTMEM_BEGIN, '0);
        @(posedge core_clock);
        #1;
        embed_mode = 1'b0;
        wait_for_window(NE_INTMEM_BEGIN);
        embed_model = 1'b0;
        finish_test("embed mode", start_err);
    endtask

    task automatic test_gpio();
        int                   start_err;
        int                   n;
        logic [WB_DATA_W-1:0] d;
        logic [WB_DATA_W-1:0] rd;
        logic                 a;
        logic                 e;
        start_err = errors;
        d = rand16();
        gpio_out_model = d[GPIO_N-1:0];
        write_expect(0, GPIO_OUT_ADDR, 2'b11, pad_gpio(gpio_out_model));
        d = rand16();
        gpio_dir_model = d[GPIO_N-1:0];
        write_expect(0, GPIO_DIR_ADDR, 2'b11, pad_gpio(gpio_dir_model));
        check_gpio("o_gpio_out", gpio_out, gpio_out_model);
        check_gpio("o_gpio_dir", gpio_dir, gpio_dir_model);
        read_expect(1, GPIO_OUT_ADDR, pad_gpio(gpio_out_model));
        read_expect(1, GPIO_DIR_ADDR, pad_gpio(gpio_dir_model));
        d = rand16();
        @(posedge core_clock);
        #1;
        gpio_in = d[GPIO_N-1:0];
        n = 0;
        do begin
            bus_read(1, GPIO_IN_ADDR, rd, a, e);
            n++;
        end while (rd !== pad_gpio(gpio_in) && n < 10);
        check_resp("o_m1_ack/o_m1_err @GPIO_IN_ADDR", a, e, TGT_GPIO);
        check_data("o_m1_dat @GPIO_IN_ADDR", rd, pad_gpio(gpio_in));
        finish_test("gpio", start_err);
    endtask

    task automatic test_divider();
        int   start_err;
        int   d_list [3];
        int   rise [2];
        int   n_rise;
        int   n;
        logic prev;
        start_err = errors;
        d_list[0] = 0;
        d_list[1] = 3;
        d_list[2] = 15;
        for (int i = 0; i < 3; i++) begin
            write_expect(0, CLK_DIV_ADDR, 2'b11, 16'(d_list[i]));
            read_expect(1, CLK_DIV_ADDR, '0);
            n_rise = 0;
            n = 0;
            @(negedge core_clock);
            prev = div_clk;
            while (n_rise < 2 && n < 100) begin
                @(negedge core_clock);
                if (div_clk && !prev) begin
                    rise[n_rise] = cycle_cnt;
                    n_rise++;
                end
                prev = div_clk;
                n++;
            end
            if (n_rise < 2) begin
                $display("o_div_clk stopped toggling with divide value %0d", d_list[i]);
                errors++;
            end else if (rise[1] - rise[0] != 2 * (d_list[i] + 1)) begin
                $display("Error: o_div_clk period = %h, expected %h",
                         rise[1] - rise[0], 2 * (d_list[i] + 1));
                errors++;
            end
        end
        finish_test("clock divider", start_err);
    endtask

    task automatic test_unmapped();
        int                   start_err;
        logic [WB_ADDR_W-1:0] bad_adr [4];
        logic [WB_DATA_W-1:0] rd;
        logic                 a;
        logic                 e;
        start_err = errors;
        bad_adr[0] = 24'h000000;
        bad_adr[1] = 24'h7fff00;
        bad_adr[2] = 24'h001002;
        bad_adr[3] = 24'h001013;
        for (int i = 0; i < 4; i++) begin
            write_expect(0, bad_adr[i], 2'b11, rand16());
            bus_read(1, bad_adr[i], rd, a, e);
            check_resp($sformatf("o_m1_ack/o_m1_err read @%h", bad_adr[i]), a, e, TGT_NONE);
        end
        check_gpio("o_gpio_out", gpio_out, gpio_out_model);
        check_gpio("o_gpio_dir", gpio_dir, gpio_dir_model);
        read_expect(0, NE_INTMEM_BEGIN, mem_model[0]);
        read_expect(0, NE_INTMEM_BEGIN + 24'd2, mem_model[2]);
        finish_test("unmapped addresses", start_err);
    endtask

    task automatic test_arbitration();
        int                   start_err;
        int                   n;
        logic [WB_DATA_W-1:0] d0;
        logic [WB_DATA_W-1:0] d1;
        logic                 a0;
        logic                 e0;
        logic                 a1;
        logic                 e1;
        start_err = errors;
        d0 = rand16();
        d1 = rand16();
        drop_cyc[0] = -1;
        fork
            bus_write(0, NE_INTMEM_BEGIN + 24'h20, 2'b11, d0, a0, e0);
            bus_write(1, NE_INTMEM_BEGIN + 24'h21, 2'b11, d1, a1, e1);
            begin
                n = 0;
                while (drop_cyc[0] < 0 && n < BUS_TIMEOUT) begin
                    @(negedge core_clock);
                    if (m_ack[1] || m_err[1]) begin
                        $display("Master 1 saw a response while master 0 held the bus");
                        errors++;
                    end
                    n++;
                end
            end
        join
        check_resp("o_m0_ack/o_m0_err arbitrated write", a0, e0, TGT_IRAM);
        check_resp("o_m1_ack/o_m1_err arbitrated write", a1, e1, TGT_IRAM);
        if (ack_cyc[0] >= ack_cyc[1]) begin
            $display("Master 0 did not complete before master 1");
            errors++;
        end
        if (ack_cyc[1] <= drop_cyc[0]) begin
            $display("Master 1 completed before master 0 dropped cyc");
            errors++;
        end
        mem_model[8'h20] = d0;
        mem_model[8'h21] = d1;
        read_expect(1, NE_INTMEM_BEGIN + 24'h20, d0);
        read_expect(0, NE_INTMEM_BEGIN + 24'h21, d1);
        finish_test("arbitration", start_err);
    endtask

    initial begin
        core_reset     = 1'b1;
        m_cyc          = '0;
        m_stb          = '0;
        m_we           = '0;
        m_adr          = '0;
        m_sel          = '0;
        m_dat          = '0;
        embed_mode     = 1'b0;
        gpio_in        = '0;
        errors         = 0;
        tests          = 0;
        embed_model    = 1'b0;
        gpio_out_model = '0;
        gpio_dir_model = '0;
        repeat (10) @(posedge core_clock);
        #1;
        core_reset = 1'b0;

        // State right after reset
        @(negedge core_clock);
        check_gpio("o_gpio_out", gpio_out, '0);
        check_gpio("o_gpio_dir", gpio_dir, '0);
        if (div_clk !== 1'b0 || m_ack !== 2'b00 || m_err !== 2'b00) begin
            $display("Error: o_div_clk = %h, {o_m1_ack,o_m0_ack} = %h, %s = %h, expected 0",
                     div_clk, m_ack, "{o_m1_err,o_m0_err}", m_err);
            errors++;
        end

        test_ram_normal();
        test_embed();
        test_gpio();
        test_divider();
        test_unmapped();
        test_arbitration();

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
logic/interconnect_pkg.sv
logic/wb_bus_if.sv
logic/wb_arbiter.sv
logic/wb_target_select.sv
logic/wb_iram.sv
logic/wb_gpio.sv
logic/clk_div.sv
logic/interconnect_outer.sv
sim/tb_interconnect_outer.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the interconnect testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_interconnect_outer -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
